// File: include/hazard_defines.svh
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Datapath word
`define DATA_W 32

// Register file geometry
`define REG_AW 5
`define REG_N  32

`endif

// File: hdl/hazardPkg.sv
`include "hazard_defines.svh"

package hazardPkg;

	typedef enum logic [1:0] {
		ID_FWD_NONE = 2'b00,
		ID_FWD_WB   = 2'b01,
		ID_FWD_MEM1 = 2'b10,
		ID_FWD_MEM2 = 2'b11
	} idFwd_e;

	// Named by where the producer sits once the consumer is in EX
	typedef enum logic [1:0] {
		EX_FWD_NONE = 2'b00,
		EX_FWD_MEM1 = 2'b01,
		EX_FWD_MEM2 = 2'b10,
		EX_FWD_WB   = 2'b11
	} exFwd_e;

	typedef struct packed {
		logic               rfWr;
		logic               dmRd; // Load
		logic               cp0Rd;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd; // Destination
		logic [`DATA_W-1:0] result;
	} stageDesc_t;

	typedef struct packed {
		stageDesc_t         desc; // Result filled in EX
		logic [`DATA_W-1:0] imm;
		logic [`DATA_W-1:0] rsData;
		logic [`DATA_W-1:0] rtData;
		exFwd_e             rsSel;
		exFwd_e             rtSel;
	} exPayload_t;

endpackage

// File: hdl/hazardCtrl.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazardCtrl (
	input  logic [`REG_AW-1:0] exRt,
	input  logic [`REG_AW-1:0] mem1Rt,
	input  logic [`REG_AW-1:0] mem2Rt,
	input  logic [`REG_AW-1:0] idRs,
	input  logic [`REG_AW-1:0] idRt,
	input  logic               exDmRd,
	input  logic               mem1DmRd,
	input  logic               mem2DmRd,
	input  logic               idBjOp,
	input  logic               exRfWr,
	input  logic               mem1RfWr,
	input  logic               mem2RfWr,
	input  logic               exCp0Rd,
	input  logic               mem1Cp0Rd,
	input  logic               mem1Ex,
	input  logic               mem1EretFlush,
	input  logic               isBusy,
	input  logic               hiloAccess,
	input  logic               iCacheDataOk,
	input  logic               dCacheDataOk,
	output logic               pcWr,
	output logic               ifIdWr,
	output logic               idExWr,
	output logic               exMem1Wr,
	output logic               mem1Mem2Wr,
	output logic               mem2WbWr,
	output logic               idBubble,
	output logic               flush,
	output logic               isStall,
	output logic               dataOk
);

	logic stallEx, stallMem1, stallMem2;
	logic dataStall, dcacheStall, mulStall;

	// Producer still too young to forward its value
	assign stallEx   = (exDmRd | exCp0Rd | idBjOp) & exRfWr &
	                   ((exRt == idRs) | (exRt == idRt));
	assign stallMem1 = (mem1DmRd | mem1Cp0Rd) & mem1RfWr &
	                   ((mem1Rt == idRs) | (mem1Rt == idRt));
	assign stallMem2 = idBjOp & mem2DmRd & mem2RfWr &
	                   ((mem2Rt == idRs) | (mem2Rt == idRt)); // Branch compares in ID

	assign dataStall   = stallEx | stallMem1 | stallMem2;
	assign dcacheStall = (~dCacheDataOk & mem2DmRd) | ~iCacheDataOk;
	assign mulStall    = isBusy & hiloAccess;

	assign flush   = mem1Ex | mem1EretFlush;
	assign dataOk  = dCacheDataOk | ~mem2DmRd; // No load waiting in MEM2
	assign isStall = ~flush & (dcacheStall | mulStall | dataStall);

	always_comb begin
		pcWr       = 1'b1;
		ifIdWr     = 1'b1;
		idExWr     = 1'b1;
		exMem1Wr   = 1'b1;
		mem1Mem2Wr = 1'b1;
		mem2WbWr   = 1'b1;
		idBubble   = 1'b0;
		if (flush) begin
			mem1Mem2Wr = dataOk;
			mem2WbWr   = dataOk;
		end else if (dcacheStall) begin
			pcWr       = 1'b0; // Whole pipe frozen
			ifIdWr     = 1'b0;
			idExWr     = 1'b0;
			exMem1Wr   = 1'b0;
			mem1Mem2Wr = 1'b0;
			mem2WbWr   = 1'b0;
		end else if (mulStall | dataStall) begin
			pcWr     = 1'b0;
			ifIdWr   = 1'b0;
			idBubble = 1'b1; // Older stages drain
		end
	end

endmodule

// File: hdl/bypassUnit.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module bypassUnit import hazardPkg::*; (
	input  logic [`REG_AW-1:0] idRs,
	input  logic [`REG_AW-1:0] idRt,
	input  logic [`REG_AW-1:0] exRd,
	input  logic [`REG_AW-1:0] mem1Rd,
	input  logic [`REG_AW-1:0] mem2Rd,
	input  logic [`REG_AW-1:0] wbRd,
	input  logic               exRfWr,
	input  logic               mem1RfWr,
	input  logic               mem2RfWr,
	input  logic               wbRfWr,
	output idFwd_e             idRsSel,
	output idFwd_e             idRtSel,
	output exFwd_e             exRsSel,
	output exFwd_e             exRtSel
);

	function automatic logic hit(input logic wr, input logic [`REG_AW-1:0] dst,
	                             input logic [`REG_AW-1:0] src);
		hit = wr && (dst != '0) && (dst == src); // $0 is never a producer
	endfunction

	// Youngest producer wins
	always_comb begin
		if (hit(mem1RfWr, mem1Rd, idRs))     idRsSel = ID_FWD_MEM1;
		else if (hit(mem2RfWr, mem2Rd, idRs)) idRsSel = ID_FWD_MEM2;
		else if (hit(wbRfWr, wbRd, idRs))     idRsSel = ID_FWD_WB;
		else                                   idRsSel = ID_FWD_NONE;
	end

	always_comb begin
		if (hit(mem1RfWr, mem1Rd, idRt))     idRtSel = ID_FWD_MEM1;
		else if (hit(mem2RfWr, mem2Rd, idRt)) idRtSel = ID_FWD_MEM2;
		else if (hit(wbRfWr, wbRd, idRt))     idRtSel = ID_FWD_WB;
		else                                   idRtSel = ID_FWD_NONE;
	end

	// Producers one stage further on by the time the consumer is in EX
	always_comb begin
		if (hit(exRfWr, exRd, idRs))          exRsSel = EX_FWD_MEM1;
		else if (hit(mem1RfWr, mem1Rd, idRs)) exRsSel = EX_FWD_MEM2;
		else if (hit(mem2RfWr, mem2Rd, idRs)) exRsSel = EX_FWD_WB;
		else                                   exRsSel = EX_FWD_NONE;
	end

	always_comb begin
		if (hit(exRfWr, exRd, idRt))          exRtSel = EX_FWD_MEM1;
		else if (hit(mem1RfWr, mem1Rd, idRt)) exRtSel = EX_FWD_MEM2;
		else if (hit(mem2RfWr, mem2Rd, idRt)) exRtSel = EX_FWD_WB;
		else                                   exRtSel = EX_FWD_NONE;
	end

endmodule

// File: hdl/stageReg.sv
`timescale 1ns/1ps

module stageReg import hazardPkg::*; #(
	parameter type T = stageDesc_t
) (
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  logic bubble,
	input  T     d,
	output T     q
);

	always_ff @(posedge clk) begin
		if (rst || (wr && bubble)) begin
			q <= '0; // rfWr cleared, slot is a nop
		end else if (wr) begin
			q <= d;
		end
	end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module regFile (
	input  logic               clk,
	input  logic               rst,
	input  logic [`REG_AW-1:0] raddr0,
	input  logic [`REG_AW-1:0] raddr1,
	input  logic [`REG_AW-1:0] waddr,
	input  logic               we,
	input  logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdata0,
	output logic [`DATA_W-1:0] rdata1
);

	logic [`DATA_W-1:0] regs [`REG_N];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata; // $0 stays zero
		end
	end

	assign rdata0 = regs[raddr0];
	assign rdata1 = regs[raddr1];

endmodule

// File: hdl/operandMux.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module operandMux import hazardPkg::*; #(
	parameter bit isExSide = 1'b0
) (
	input  logic [1:0]         sel0,
	input  logic [1:0]         sel1,
	input  logic [`DATA_W-1:0] base0,
	input  logic [`DATA_W-1:0] base1,
	input  logic [`DATA_W-1:0] mem1Data,
	input  logic [`DATA_W-1:0] mem2Data,
	input  logic [`DATA_W-1:0] wbData,
	output logic [`DATA_W-1:0] op0,
	output logic [`DATA_W-1:0] op1
);

	function automatic logic [`DATA_W-1:0] pick(
		input logic [1:0]         sel,
		input logic [`DATA_W-1:0] base,
		input logic [`DATA_W-1:0] m1,
		input logic [`DATA_W-1:0] m2,
		input logic [`DATA_W-1:0] wb
	);
		pick = base;
		if (isExSide) begin
			case (exFwd_e'(sel))
				EX_FWD_MEM1: pick = m1;
				EX_FWD_MEM2: pick = m2;
				EX_FWD_WB:   pick = wb;
				default:     pick = base;
			endcase
		end else begin
			case (idFwd_e'(sel)) // Same sources, different code order
				ID_FWD_MEM1: pick = m1;
				ID_FWD_MEM2: pick = m2;
				ID_FWD_WB:   pick = wb;
				default:     pick = base;
			endcase
		end
	endfunction

	assign op0 = pick(sel0, base0, mem1Data, mem2Data, wbData);
	assign op1 = pick(sel1, base1, mem1Data, mem2Data, wbData);

endmodule

// File: hdl/hazardPipe.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazardPipe import hazardPkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic [`REG_AW-1:0] idRs,
	input  logic [`REG_AW-1:0] idRt,
	input  logic [`REG_AW-1:0] idRd,
	input  logic [`DATA_W-1:0] idImm,
	input  logic               idRfWr,
	input  logic               idDmRd,
	input  logic               idCp0Rd,
	input  logic               idBjOp,
	input  logic               mem1Ex,
	input  logic               mem1EretFlush,
	input  logic               isBusy,
	input  logic               hiloAccess,
	input  logic               iCacheDataOk,
	input  logic               dCacheDataOk,
	input  logic [`DATA_W-1:0] dCacheRdata,
	output logic               pcWr,
	output logic               ifIdWr,
	output logic               isStall,
	output logic               dataOk,
	output logic [`DATA_W-1:0] exRsData,
	output logic [`DATA_W-1:0] exRtData,
	output logic               wbRfWr,
	output logic [`REG_AW-1:0] wbRd,
	output logic [`DATA_W-1:0] wbData
);

	exPayload_t exQ;
	stageDesc_t mem1Q, mem2Q, wbQ;
	logic idExWr, exMem1Wr, mem1Mem2Wr, mem2WbWr, idBubble, flush;
	idFwd_e idRsSel, idRtSel;
	exFwd_e exRsSel, exRtSel;
	logic [`DATA_W-1:0] rfRs, rfRt, idRsData, idRtData;
	wire [`DATA_W-1:0] mem2Result = mem2Q.dmRd ? dCacheRdata : mem2Q.result; // Load data

	hazardCtrl i_ctrl (
		.exRt(exQ.desc.rt), .mem1Rt(mem1Q.rt), .mem2Rt(mem2Q.rt),
		.idRs(idRs), .idRt(idRt),
		.exDmRd(exQ.desc.dmRd), .mem1DmRd(mem1Q.dmRd), .mem2DmRd(mem2Q.dmRd),
		.idBjOp(idBjOp),
		.exRfWr(exQ.desc.rfWr), .mem1RfWr(mem1Q.rfWr), .mem2RfWr(mem2Q.rfWr),
		.exCp0Rd(exQ.desc.cp0Rd), .mem1Cp0Rd(mem1Q.cp0Rd),
		.mem1Ex(mem1Ex), .mem1EretFlush(mem1EretFlush),
		.isBusy(isBusy), .hiloAccess(hiloAccess),
		.iCacheDataOk(iCacheDataOk), .dCacheDataOk(dCacheDataOk),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .idExWr(idExWr), .exMem1Wr(exMem1Wr),
		.mem1Mem2Wr(mem1Mem2Wr), .mem2WbWr(mem2WbWr),
		.idBubble(idBubble), .flush(flush), .isStall(isStall), .dataOk(dataOk)
	);

	bypassUnit i_bypass (
		.idRs(idRs), .idRt(idRt),
		.exRd(exQ.desc.rd), .mem1Rd(mem1Q.rd), .mem2Rd(mem2Q.rd), .wbRd(wbQ.rd),
		.exRfWr(exQ.desc.rfWr), .mem1RfWr(mem1Q.rfWr),
		.mem2RfWr(mem2Q.rfWr), .wbRfWr(wbQ.rfWr),
		.idRsSel(idRsSel), .idRtSel(idRtSel), .exRsSel(exRsSel), .exRtSel(exRtSel)
	);

	regFile i_rf (
		.clk(clk), .rst(rst),
		.raddr0(idRs), .raddr1(idRt),
		.waddr(wbQ.rd), .we(wbQ.rfWr), .wdata(wbQ.result),
		.rdata0(rfRs), .rdata1(rfRt)
	);

	operandMux #(.isExSide(1'b0)) i_idMux (
		.sel0(idRsSel), .sel1(idRtSel), .base0(rfRs), .base1(rfRt),
		.mem1Data(mem1Q.result), .mem2Data(mem2Result), .wbData(wbQ.result),
		.op0(idRsData), .op1(idRtData)
	);

	operandMux #(.isExSide(1'b1)) i_exMux (
		.sel0(exQ.rsSel), .sel1(exQ.rtSel), .base0(exQ.rsData), .base1(exQ.rtData),
		.mem1Data(mem1Q.result), .mem2Data(mem2Result), .wbData(wbQ.result),
		.op0(exRsData), .op1(exRtData)
	);

	stageReg #(.T(exPayload_t)) i_idExReg (
		.clk(clk), .rst(rst), .wr(idExWr), .bubble(idBubble | flush),
		.d(exPayload_t'{
			desc: stageDesc_t'{rfWr: idRfWr, dmRd: idDmRd, cp0Rd: idCp0Rd,
			                   rt: idRt, rd: idRd, result: '0},
			imm: idImm, rsData: idRsData, rtData: idRtData,
			rsSel: exRsSel, rtSel: exRtSel}),
		.q(exQ)
	);

	// ALU result is rs plus immediate
	stageReg #(.T(stageDesc_t)) i_exMem1Reg (
		.clk(clk), .rst(rst), .wr(exMem1Wr), .bubble(flush),
		.d(stageDesc_t'{rfWr: exQ.desc.rfWr, dmRd: exQ.desc.dmRd, cp0Rd: exQ.desc.cp0Rd,
		                rt: exQ.desc.rt, rd: exQ.desc.rd, result: exRsData + exQ.imm}),
		.q(mem1Q)
	);

	stageReg #(.T(stageDesc_t)) i_mem1Mem2Reg (
		.clk(clk), .rst(rst), .wr(mem1Mem2Wr), .bubble(flush),
		.d(mem1Q), .q(mem2Q)
	);

	stageReg #(.T(stageDesc_t)) i_mem2WbReg (
		.clk(clk), .rst(rst), .wr(mem2WbWr), .bubble(1'b0),
		.d(stageDesc_t'{rfWr: mem2Q.rfWr, dmRd: mem2Q.dmRd, cp0Rd: mem2Q.cp0Rd,
		                rt: mem2Q.rt, rd: mem2Q.rd, result: mem2Result}),
		.q(wbQ)
	);

	assign wbRfWr = wbQ.rfWr;
	assign wbRd   = wbQ.rd;
	assign wbData = wbQ.result;

endmodule

// File: verif/hazardPipeTb.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazardPipeTb;

	localparam int CLK_NS   = 4;
	localparam int PHASE_N  = 80;
	localparam int PHASES   = 6;
	localparam int LIMIT_NS = (PHASES * PHASE_N * 200 + 5) * CLK_NS;

	typedef struct packed {
		logic               v;
		logic               wr;
		logic               ld;
		logic               cp0;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [`DATA_W-1:0] res;
		logic [`DATA_W-1:0] rsv;
		logic [`DATA_W-1:0] rtv;
		logic [`DATA_W-1:0] ldData;
	} slot_t;

	logic clk, rst, idRfWr, idDmRd, idCp0Rd, idBjOp, pcWr, ifIdWr, isStall, dataOk, wbRfWr;
	logic mem1Ex, mem1EretFlush, isBusy, hiloAccess, iCacheDataOk, dCacheDataOk;
	logic [`REG_AW-1:0] idRs, idRt, idRd, wbRd;
	logic [`DATA_W-1:0] idImm, dCacheRdata, exRsData, exRtData, wbData, ldData;
	slot_t pipe [4]; // EX, MEM1, MEM2, WB
	logic [`DATA_W-1:0] arch [`REG_N];
	logic [`DATA_W-1:0] spec [`REG_N]; // Arch state plus writes still in flight
	logic [31:0] lfsr;
	logic idValid, taken, flushIn, stEx, stMem1, stMem2, expStall, expDataOk, expFront;
	logic advWb;
	string testName;

	hazardPipe i_dut (.*);

	assign flushIn   = mem1Ex | mem1EretFlush;
	assign stEx      = (pipe[0].ld | pipe[0].cp0 | idBjOp) & pipe[0].wr &
	                   (pipe[0].rt == idRs || pipe[0].rt == idRt);
	assign stMem1    = (pipe[1].ld | pipe[1].cp0) & pipe[1].wr &
	                   (pipe[1].rt == idRs || pipe[1].rt == idRt);
	assign stMem2    = idBjOp & pipe[2].ld & pipe[2].wr & (pipe[2].rt == idRs || pipe[2].rt == idRt);
	assign expDataOk = dCacheDataOk | ~pipe[2].ld;
	assign expStall  = stEx | stMem1 | stMem2 | ~expDataOk | ~iCacheDataOk | (isBusy & hiloAccess);
	assign expFront  = flushIn | ~expStall;
	assign advWb     = expDataOk & (flushIn | iCacheDataOk); // MEM2 moves on to WB

	always @(posedge clk) begin
		slot_t s;
		if (rst) begin
			for (int i = 0; i < 4; i++) pipe[i] <= '0;
			for (int i = 0; i < `REG_N; i++) begin
				arch[i] <= '0;
				spec[i] <= '0;
			end
			taken <= 1'b1;
		end else begin
			s = '{v: idValid, wr: idRfWr, ld: idDmRd, cp0: idCp0Rd, rt: idRt, rd: idRd,
			      res: '0, rsv: spec[idRs], rtv: spec[idRt], ldData: ldData};
			s.res = idDmRd ? ldData : s.rsv + idImm;
			taken <= expFront;
			if (advWb && pipe[2].wr && pipe[2].rd != '0) arch[pipe[2].rd] <= pipe[2].res;
			if (flushIn) begin
				pipe[0] <= '0; // ID, EX and MEM1 are killed
				pipe[1] <= '0;
				if (expDataOk) begin
					pipe[2] <= '0;
					pipe[3] <= pipe[2];
				end
				for (int i = 0; i < `REG_N; i++) spec[i] <= arch[i];
				if (pipe[2].wr && pipe[2].rd != '0) spec[pipe[2].rd] <= pipe[2].res;
			end else if (advWb) begin
				pipe[3] <= pipe[2];
				pipe[2] <= pipe[1];
				pipe[1] <= pipe[0];
				pipe[0] <= expFront ? s : '0;
				if (expFront && idRfWr && idRd != '0) spec[idRd] <= s.res;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) pipe[0].v |-> exRsData == pipe[0].rsv)
		else failValue("exRsData", $sampled(pipe[0].rsv), $sampled(exRsData));
	assert property (@(posedge clk) disable iff (rst) pipe[0].v |-> exRtData == pipe[0].rtv)
		else failValue("exRtData", $sampled(pipe[0].rtv), $sampled(exRtData));
	assert property (@(posedge clk) disable iff (rst) wbRfWr == pipe[3].wr)
		else failValue("wbRfWr", 32'($sampled(pipe[3].wr)), 32'($sampled(wbRfWr)));
	assert property (@(posedge clk) disable iff (rst) pipe[3].wr |-> wbRd == pipe[3].rd)
		else failValue("wbRd", 32'($sampled(pipe[3].rd)), 32'($sampled(wbRd)));
	assert property (@(posedge clk) disable iff (rst) pipe[3].wr |-> wbData == pipe[3].res)
		else failValue("wbData", $sampled(pipe[3].res), $sampled(wbData));
	assert property (@(posedge clk) disable iff (rst) isStall == ~expFront)
		else failValue("isStall", 32'($sampled(~expFront)), 32'($sampled(isStall)));
	assert property (@(posedge clk) disable iff (rst) pcWr == expFront && ifIdWr == expFront)
		else failValue("pcWr,ifIdWr", 32'($sampled({2{expFront}})), 32'($sampled({pcWr, ifIdWr})));
	assert property (@(posedge clk) disable iff (rst) dataOk == expDataOk)
		else failValue("dataOk", 32'($sampled(expDataOk)), 32'($sampled(dataOk)));

	task automatic failValue(input string what, input logic [31:0] expV, input logic [31:0] actV);
		$display("** Error [%s] %s: expected %h, actual %h", testName, what, expV, actV);
		$display("test failed");
		$fatal(1, "value mismatch");
	endtask

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32,22,2,1
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [`REG_AW-1:0] pickReg();
		logic [31:0] r;
		r = takeBits(3); // $0..$7 keeps hazards dense
		return r[`REG_AW-1:0];
	endfunction

	task automatic drawInstr(input logic [4:0] knobs);
		idValid = 1'b1;
		idRs    = pickReg();
		idRt    = pickReg();
		idRd    = pickReg();
		idImm   = takeBits(32);
		idRfWr  = takeBits(2) != 0;
		idDmRd  = knobs[0] && takeBits(2) == 0;
		idCp0Rd = knobs[1] && takeBits(3) == 0;
		idBjOp  = knobs[1] && takeBits(2) == 0;
		ldData  = takeBits(32);
		if (idDmRd) begin
			idRfWr = 1'b1;
			idRd   = idRt; // Loads write rt
		end
	endtask

	task automatic driveNoise(input logic [4:0] knobs);
		iCacheDataOk  = !(knobs[2] && takeBits(3) == 0);
		dCacheDataOk  = !(knobs[2] && takeBits(2) == 0);
		isBusy        = knobs[3] && takeBits(1) != 0;
		hiloAccess    = knobs[3] && takeBits(1) != 0;
		mem1Ex        = knobs[4] && takeBits(5) == 0;
		mem1EretFlush = knobs[4] && takeBits(6) == 0;
		dCacheRdata   = pipe[2].ldData;
	endtask

	task automatic idleId();
		{idValid, idRfWr, idDmRd, idCp0Rd, idBjOp} = '0;
		{idRs, idRt, idRd, idImm, ldData} = '0;
	endtask

	// Knobs are flush, mul, cache, branch/cp0, load
	task automatic runPhase(input string name, input logic [4:0] knobs);
		int issued;
		issued = 0;
		testName = name;
		while (issued < PHASE_N) begin
			@(negedge clk);
			if (taken) begin
				drawInstr(knobs);
				issued++;
			end
			driveNoise(knobs);
		end
	endtask

	task automatic drainPipe();
		testName = "drain";
		do begin
			@(negedge clk);
			driveNoise(5'b0);
		end while (!taken);
		idleId();
		while (pipe[0].v || pipe[1].v || pipe[2].v || pipe[3].v) begin
			@(negedge clk);
			driveNoise(5'b0);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(LIMIT_NS);
		$display("Watchdog expired during %s, the pipeline stopped making progress", testName);
		$display("test failed");
		$fatal(1, "timeout");
	end

	initial begin
		lfsr = 32'h9168_4cc7;
		testName = "reset";
		rst = 1'b1;
		idleId();
		{mem1Ex, mem1EretFlush, isBusy, hiloAccess} = '0;
		{iCacheDataOk, dCacheDataOk} = 2'b11;
		dCacheRdata = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		runPhase("forwarding", 5'b00000);
		runPhase("loadUse", 5'b00001);
		runPhase("branchHazard", 5'b00011);
		runPhase("cacheStall", 5'b00101);
		runPhase("mulStall", 5'b01001);
		runPhase("flush", 5'b11111);
		drainPipe();
		$display("test passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
hdl/hazardPkg.sv
hdl/hazardCtrl.sv
hdl/bypassUnit.sv
hdl/stageReg.sv
hdl/regFile.sv
hdl/operandMux.sv
hdl/hazardPipe.sv
verif/hazardPipeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= hazardPipeTb
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)
